// File: rtl/fx2_macros.svh
/*
 * FX2 slave-FIFO constants
 * Frame start byte, reset command and tracking FIFO geometry
 */

`ifndef FX2_MACROS_SVH
`define FX2_MACROS_SVH

// First byte of every frame in both directions
`define FX2_HEADER_BYTE 8'hFF

// Command identifier presented before any EP4 packet arrives
`define FX2_COMMAND_NOP 8'h38

// Tracking FIFO ports and their address width
`define FX2_NUM_PORTS 4
`define FX2_FIFO_ADDR_WIDTH 11

`endif

// File: rtl/fx2_bus_pkg.sv
/*
 * FX2 bus types
 * Endpoint addresses, packet framing status and the bus byte
 */

package fx2_bus_pkg;

    // Endpoint address as driven onto usb_addr
    // EP8 exists on the FX2 but is never selected here
    typedef enum logic [1:0] {
        EP2 = 2'd0,
        EP4 = 2'd1,
        EP6 = 2'd2,
        EP8 = 2'd3
    } endpoint_t;

    // Position within a frame, kept per endpoint so a packet can resume
    typedef enum logic [2:0] {
        pkt_waiting        = 3'd0,
        pkt_header_command = 3'd1,
        pkt_length_upper   = 3'd2,
        pkt_length_lower   = 3'd3,
        pkt_data           = 3'd4,
        pkt_done           = 3'd5
    } packet_status_t;

    typedef logic [7:0] fx2_byte_t;

endpackage

// File: rtl/fifo_port_pkg.sv
/*
 * Tracking FIFO side types
 * Port selection, FIFO addresses, frame length and the header byte views
 */

`include "fx2_macros.svh"

package fifo_port_pkg;

    typedef logic [1:0] port_index_t;

    // One bit per tracking FIFO port
    typedef logic [`FX2_NUM_PORTS-1:0] port_mask_t;

    typedef logic [`FX2_FIFO_ADDR_WIDTH-1:0] fifo_addr_t;

    // Length field of a frame, upper byte sent first
    typedef logic [15:0] packet_length_t;

    // Second frame byte
    // EP4 reads it whole as a command id, EP2 only looks at the port field
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [5:0]  reserved;
            port_index_t port;
        } data;
    } header_cmd_u;

endpackage

// File: rtl/fx2_endpoint_arbiter.sv
/*
 * FX2 endpoint arbiter
 * Round-robin over EP2, EP4 and EP6, FX2 read strobe from the empty flags,
 * one-hot EP2 port strobes and the EP4 command strobe
 */

`timescale 1ns/100ps

module fx2_endpoint_arbiter (
    input  logic                       usb_ifclk,
    input  logic                       reset,
    input  logic                       usb_ep2_empty,
    input  logic                       usb_ep4_empty,
    input  logic                       ep2_rd_req,
    input  logic                       ep4_rd_req,
    input  logic                       ep2_release,
    input  logic                       ep4_release,
    input  logic                       ep6_release,
    input  logic                       ep2_payload,
    input  logic                       ep4_payload,
    input  fifo_port_pkg::header_cmd_u ep2_header,
    input  fifo_port_pkg::header_cmd_u ep4_header,
    output logic                       ep2_select,
    output logic                       ep4_select,
    output logic                       ep6_select,
    output logic                       ep2_take,
    output logic                       ep4_take,
    output logic                       usb_slrd,
    output logic                       usb_sloe,
    output fx2_bus_pkg::endpoint_t     usb_addr,
    output fifo_port_pkg::port_mask_t  ep2_port_write,
    output logic                       cmd_valid,
    output fx2_bus_pkg::fx2_byte_t     cmd_in_id
);
    import fx2_bus_pkg::*;
    import fifo_port_pkg::*;

    endpoint_t current_ep;
    endpoint_t next_ep;
    logic      current_release;

    assign ep2_select = (current_ep == EP2);
    assign ep4_select = (current_ep == EP4);
    assign ep6_select = (current_ep == EP6);

    // A byte is accepted only from the selected endpoint with data present
    assign ep2_take = ep2_select && ep2_rd_req && !usb_ep2_empty;
    assign ep4_take = ep4_select && ep4_rd_req && !usb_ep4_empty;

    // Both strobes active low, FX2 always drives its data bus
    assign usb_slrd = !(ep2_take || ep4_take);
    assign usb_sloe = 1'b0;
    assign usb_addr = current_ep;

    // Rotation order and the release of whoever owns the bus
    always_comb begin
        case (current_ep)
            EP2: begin
                next_ep         = EP4;
                current_release = ep2_release;
            end
            EP4: begin
                next_ep         = EP6;
                current_release = ep4_release;
            end
            EP6: begin
                next_ep         = EP2;
                current_release = ep6_release;
            end
            default: begin
                // EP8 is unused, step straight back to EP2
                next_ep         = EP2;
                current_release = 1'b1;
            end
        endcase
    end

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            current_ep <= EP2;
        end else if (current_release) begin
            current_ep <= next_ep;
        end
    end

    // Payload byte goes to the port named in the EP2 header
    assign ep2_port_write = ep2_payload ? (port_mask_t'(1) << ep2_header.data.port) : '0;

    // Command decoder sees the whole EP4 header byte as its id
    assign cmd_valid = ep4_payload;
    assign cmd_in_id = ep4_header.raw;

endmodule

// File: rtl/out_packet_reader.sv
/*
 * OUT packet reader
 * Parses one host-to-device frame, flags payload bytes as they are taken
 * and keeps its place when the endpoint is abandoned
 */

`timescale 1ns/100ps

`include "fx2_macros.svh"

module out_packet_reader (
    input  logic                       usb_ifclk,
    input  logic                       reset,
    input  logic                       select,
    input  logic                       take,
    input  fx2_bus_pkg::fx2_byte_t     usb_data_out,
    output logic                       rd_req,
    output logic                       ep_release,
    output logic                       payload,
    output fifo_port_pkg::header_cmd_u header
);
    import fx2_bus_pkg::*;
    import fifo_port_pkg::*;

    packet_status_t status;
    packet_length_t length;
    packet_length_t count;

    // Ask for bytes until the frame is finished
    assign rd_req = (status != pkt_done);

    // Payload flag is combinational with the take
    assign payload = take && (status == pkt_data);

    // Give up the bus when done, or when a started frame stalls
    assign ep_release = select &&
                        ((status == pkt_done) || ((status != pkt_waiting) && !take));

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            status     <= pkt_waiting;
            header.raw <= `FX2_COMMAND_NOP;
        end else if (select) begin
            case (status)
                pkt_waiting: begin
                    // Anything other than a start byte is dropped
                    if (take && (usb_data_out == `FX2_HEADER_BYTE)) begin
                        status <= pkt_header_command;
                    end else begin
                        status <= pkt_done;
                    end
                end
                pkt_header_command: begin
                    if (take) begin
                        header.raw <= usb_data_out;
                        status     <= pkt_length_upper;
                    end
                end
                pkt_length_upper: begin
                    if (take) begin
                        length[15:8] <= usb_data_out;
                        status       <= pkt_length_lower;
                    end
                end
                pkt_length_lower: begin
                    if (take) begin
                        length[7:0] <= usb_data_out;
                        count       <= '0;
                        // Empty frame has nothing to deliver
                        if ((length[15:8] == 8'h00) && (usb_data_out == 8'h00)) begin
                            status <= pkt_done;
                        end else begin
                            status <= pkt_data;
                        end
                    end
                end
                pkt_data: begin
                    if (take) begin
                        count <= count + 1'b1;
                        if (count == length - 1'b1) begin
                            status <= pkt_done;
                        end
                    end
                end
                default: begin
                    // Done, release is out this cycle
                    status <= pkt_waiting;
                end
            endcase
        end
    end

endmodule

// File: rtl/adc_packet_writer.sv
/*
 * ADC packet writer
 * Visits the tracking FIFO ports in turn and sends any pending bytes
 * to EP6 as one frame, paced by the FX2 full flag
 */

`timescale 1ns/100ps

`include "fx2_macros.svh"

module adc_packet_writer (
    input  logic                                             usb_ifclk,
    input  logic                                             reset,
    input  logic                                             select,
    input  logic                                             usb_ep6_full,
    input  fifo_port_pkg::fifo_addr_t [`FX2_NUM_PORTS-1:0]   ep6_port_addr_ins,
    input  fifo_port_pkg::fifo_addr_t [`FX2_NUM_PORTS-1:0]   ep6_port_addr_outs,
    input  fx2_bus_pkg::fx2_byte_t [`FX2_NUM_PORTS-1:0]      ep6_port_datas,
    output fifo_port_pkg::port_mask_t                        ep6_port_read,
    output logic                                             usb_slwr,
    output fx2_bus_pkg::fx2_byte_t                           usb_data_in,
    output logic                                             ep_release
);
    import fx2_bus_pkg::*;
    import fifo_port_pkg::*;

    packet_status_t status;
    port_index_t    port;
    fifo_addr_t     pending;
    fifo_addr_t     count;
    packet_length_t frame_length;
    logic           port_active;
    logic           emit;

    // Port has data whenever its addresses differ
    assign port_active = (ep6_port_addr_ins[port] != ep6_port_addr_outs[port]);

    // Snapshot widened to the 16-bit length field
    assign frame_length = packet_length_t'(pending);

    // A byte goes out this cycle, strobe follows on the next
    assign emit = select && !usb_ep6_full && (status != pkt_done) &&
                  ((status != pkt_waiting) || port_active);

    // FIFO advances on the same edge its byte is registered
    assign ep6_port_read = (emit && (status == pkt_data)) ? (port_mask_t'(1) << port) : '0;

    // Idle port or finished frame hands the bus back
    assign ep_release = select &&
                        ((status == pkt_done) || ((status == pkt_waiting) && !port_active));

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            status   <= pkt_waiting;
            port     <= '0;
            usb_slwr <= 1'b1;
        end else begin
            usb_slwr <= !emit;
            if (ep_release) begin
                status <= pkt_waiting;
                port   <= port + 1'b1;
            end else if (emit) begin
                case (status)
                    pkt_waiting: begin
                        // Length is fixed here, later writes wait for the next frame
                        pending     <= ep6_port_addr_ins[port] - ep6_port_addr_outs[port];
                        usb_data_in <= `FX2_HEADER_BYTE;
                        status      <= pkt_header_command;
                    end
                    pkt_header_command: begin
                        usb_data_in <= fx2_byte_t'(port);
                        status      <= pkt_length_upper;
                    end
                    pkt_length_upper: begin
                        usb_data_in <= frame_length[15:8];
                        status      <= pkt_length_lower;
                    end
                    pkt_length_lower: begin
                        usb_data_in <= frame_length[7:0];
                        count       <= '0;
                        status      <= pkt_data;
                    end
                    pkt_data: begin
                        usb_data_in <= ep6_port_datas[port];
                        count       <= count + 1'b1;
                        if (count == pending - 1'b1) begin
                            status <= pkt_done;
                        end
                    end
                    default: begin
                        status <= pkt_waiting;
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/fx2_interface.sv
/*
 * FX2 slave-FIFO interface
 * EP2 data to the tracking FIFO write ports, EP4 to the command decoder,
 * tracking FIFO read ports back to the host on EP6
 */

`timescale 1ns/100ps

`include "fx2_macros.svh"

module fx2_interface (
    input  logic                                             usb_ifclk,
    input  logic                                             reset,
    output logic                                             usb_slwr,
    output logic                                             usb_slrd,
    output logic                                             usb_sloe,
    output fx2_bus_pkg::endpoint_t                           usb_addr,
    output fx2_bus_pkg::fx2_byte_t                           usb_data_in,
    input  fx2_bus_pkg::fx2_byte_t                           usb_data_out,
    input  logic                                             usb_ep2_empty,
    input  logic                                             usb_ep4_empty,
    input  logic                                             usb_ep6_full,
    output fx2_bus_pkg::fx2_byte_t                           ep2_port_data,
    output fifo_port_pkg::port_mask_t                        ep2_port_write,
    input  fifo_port_pkg::fifo_addr_t [`FX2_NUM_PORTS-1:0]   ep6_port_addr_ins,
    input  fifo_port_pkg::fifo_addr_t [`FX2_NUM_PORTS-1:0]   ep6_port_addr_outs,
    input  fx2_bus_pkg::fx2_byte_t [`FX2_NUM_PORTS-1:0]      ep6_port_datas,
    output fifo_port_pkg::port_mask_t                        ep6_port_read,
    output fx2_bus_pkg::fx2_byte_t                           cmd_in_id,
    output fx2_bus_pkg::fx2_byte_t                           cmd_in_data,
    output logic                                             cmd_valid
);
    import fifo_port_pkg::*;

    logic        ep2_select;
    logic        ep4_select;
    logic        ep6_select;
    logic        ep2_take;
    logic        ep4_take;
    logic        ep2_rd_req;
    logic        ep4_rd_req;
    logic        ep2_release;
    logic        ep4_release;
    logic        ep6_release;
    logic        ep2_payload;
    logic        ep4_payload;
    header_cmd_u ep2_header;
    header_cmd_u ep4_header;

    // Both consumers sample the FX2 bus directly on their strobe
    assign ep2_port_data = usb_data_out;
    assign cmd_in_data   = usb_data_out;

    fx2_endpoint_arbiter arbiter0 (
        .usb_ifclk      (usb_ifclk),
        .reset          (reset),
        .usb_ep2_empty  (usb_ep2_empty),
        .usb_ep4_empty  (usb_ep4_empty),
        .ep2_rd_req     (ep2_rd_req),
        .ep4_rd_req     (ep4_rd_req),
        .ep2_release    (ep2_release),
        .ep4_release    (ep4_release),
        .ep6_release    (ep6_release),
        .ep2_payload    (ep2_payload),
        .ep4_payload    (ep4_payload),
        .ep2_header     (ep2_header),
        .ep4_header     (ep4_header),
        .ep2_select     (ep2_select),
        .ep4_select     (ep4_select),
        .ep6_select     (ep6_select),
        .ep2_take       (ep2_take),
        .ep4_take       (ep4_take),
        .usb_slrd       (usb_slrd),
        .usb_sloe       (usb_sloe),
        .usb_addr       (usb_addr),
        .ep2_port_write (ep2_port_write),
        .cmd_valid      (cmd_valid),
        .cmd_in_id      (cmd_in_id)
    );

    // EP2 data frames
    out_packet_reader ep2_reader0 (
        .usb_ifclk    (usb_ifclk),
        .reset        (reset),
        .select       (ep2_select),
        .take         (ep2_take),
        .usb_data_out (usb_data_out),
        .rd_req       (ep2_rd_req),
        .ep_release   (ep2_release),
        .payload      (ep2_payload),
        .header       (ep2_header)
    );

    // EP4 command frames
    out_packet_reader ep4_reader0 (
        .usb_ifclk    (usb_ifclk),
        .reset        (reset),
        .select       (ep4_select),
        .take         (ep4_take),
        .usb_data_out (usb_data_out),
        .rd_req       (ep4_rd_req),
        .ep_release   (ep4_release),
        .payload      (ep4_payload),
        .header       (ep4_header)
    );

    adc_packet_writer adc_writer0 (
        .usb_ifclk          (usb_ifclk),
        .reset              (reset),
        .select             (ep6_select),
        .usb_ep6_full       (usb_ep6_full),
        .ep6_port_addr_ins  (ep6_port_addr_ins),
        .ep6_port_addr_outs (ep6_port_addr_outs),
        .ep6_port_datas     (ep6_port_datas),
        .ep6_port_read      (ep6_port_read),
        .usb_slwr           (usb_slwr),
        .usb_data_in        (usb_data_in),
        .ep_release         (ep6_release)
    );

endmodule

// File: bench/fx2_checker.sv
/*
 * FX2 interface checker
 * Compares EP2 port writes, EP4 command strobes and EP6 bytes
 * with the expected queues and keeps per-test error counts
 */

`timescale 1ns/100ps

module fx2_checker (
    input logic                      usb_ifclk,
    input logic                      reset,
    input fifo_port_pkg::port_mask_t ep2_port_write,
    input fx2_bus_pkg::fx2_byte_t    ep2_port_data,
    input logic                      cmd_valid,
    input fx2_bus_pkg::fx2_byte_t    cmd_in_id,
    input fx2_bus_pkg::fx2_byte_t    cmd_in_data,
    input logic                      usb_slwr,
    input fx2_bus_pkg::fx2_byte_t    usb_data_in
);
    import fx2_bus_pkg::*;
    import fifo_port_pkg::*;

    // EP2 entries carry the port mask above the data byte
    logic [11:0] exp_ep2 [$];
    logic [15:0] exp_cmd [$];
    fx2_byte_t   exp_ep6 [$];
    int          error_count = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] got);
        if (expected !== got) begin
            $display("ERROR %s expected %h got %h", name, expected, got);
            note_error();
        end
    endtask

    task automatic expect_ep2(input port_index_t port, input fx2_byte_t data);
        exp_ep2.push_back({port_mask_t'(1) << port, data});
    endtask

    task automatic expect_cmd(input fx2_byte_t id, input fx2_byte_t data);
        exp_cmd.push_back({id, data});
    endtask

    task automatic expect_ep6(input fx2_byte_t data);
        exp_ep6.push_back(data);
    endtask

    function automatic int pending();
        return exp_ep2.size() + exp_cmd.size() + exp_ep6.size();
    endfunction

    always @(posedge usb_ifclk) begin
        if (!reset) begin
            if (ep2_port_write != '0) begin
                if (exp_ep2.size() == 0) begin
                    $display("EP2 write to mask %h with no byte expected", ep2_port_write);
                    note_error();
                end else begin
                    check_value("ep2_port_write", 16'(exp_ep2[0][11:8]), 16'(ep2_port_write));
                    check_value("ep2_port_data", 16'(exp_ep2[0][7:0]), 16'(ep2_port_data));
                    void'(exp_ep2.pop_front());
                end
            end
            if (cmd_valid) begin
                if (exp_cmd.size() == 0) begin
                    $display("Command strobe with id %h and no command expected", cmd_in_id);
                    note_error();
                end else begin
                    check_value("cmd_in_id", 16'(exp_cmd[0][15:8]), 16'(cmd_in_id));
                    check_value("cmd_in_data", 16'(exp_cmd[0][7:0]), 16'(cmd_in_data));
                    void'(exp_cmd.pop_front());
                end
            end
            // EP6 byte is valid while the write strobe is low
            if (!usb_slwr) begin
                if (exp_ep6.size() == 0) begin
                    $display("EP6 byte %h written with no frame pending", usb_data_in);
                    note_error();
                end else begin
                    check_value("usb_data_in", 16'(exp_ep6[0]), 16'(usb_data_in));
                    void'(exp_ep6.pop_front());
                end
            end
        end
    end

    // Anything still queued here never reached the DUT outputs
    task automatic finish_test(input string name);
        if (pending() != 0) begin
            $display("%s: %0d expected bytes never arrived", name, pending());
            note_error();
            exp_ep2.delete();
            exp_cmd.delete();
            exp_ep6.delete();
        end
        $display("%-14s %s (%0d errors)", name, (test_errors == 0) ? "PASS" : "FAIL",
                 test_errors);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        test_errors = 0;
    endtask

    task automatic report_totals();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
    endtask

endmodule

// File: bench/tb_fx2_interface.sv
/*
 * FX2 interface testbench
 * Host byte queues for EP2 and EP4, four tracking FIFO models for EP6,
 * the frame reference function and the test sequence
 */

`timescale 1ns/100ps

`include "fx2_macros.svh"

module tb_fx2_interface;
    import fx2_bus_pkg::*;
    import fifo_port_pkg::*;

    typedef fx2_byte_t byte_q_t [$];

    logic        usb_ifclk = 1'b0;
    logic        reset = 1'b1;
    logic        usb_slwr;
    logic        usb_slrd;
    logic        usb_sloe;
    endpoint_t   usb_addr;
    fx2_byte_t   usb_data_in;
    fx2_byte_t   usb_data_out = 8'h00;
    logic        usb_ep2_empty = 1'b1;
    logic        usb_ep4_empty = 1'b1;
    logic        usb_ep6_full = 1'b0;
    fx2_byte_t   ep2_port_data;
    port_mask_t  ep2_port_write;
    port_mask_t  ep6_port_read;
    fx2_byte_t   cmd_in_id;
    fx2_byte_t   cmd_in_data;
    logic        cmd_valid;
    fifo_addr_t [`FX2_NUM_PORTS-1:0] port_addr_ins;
    fifo_addr_t [`FX2_NUM_PORTS-1:0] port_addr_outs;
    fx2_byte_t [`FX2_NUM_PORTS-1:0]  port_datas;

    // Host side of the FX2 OUT endpoints
    byte_q_t     ep2_queue;
    byte_q_t     ep4_queue;
    logic        stall_en = 1'b0;

    // Tracking FIFOs with ports 0 and 2 starting near the top to force a wrap
    fx2_byte_t   fifo_mem [4][2048];
    fifo_addr_t  in_addr [4] = '{11'd2040, 11'd0, 11'd2030, 11'd1000};
    fifo_addr_t  out_addr [4] = '{11'd2040, 11'd0, 11'd2030, 11'd1000};

    int          total_bytes = 0;
    int          cycles = 0;

    fx2_interface dut0 (
        .usb_ifclk(usb_ifclk), .reset(reset), .usb_slwr(usb_slwr), .usb_slrd(usb_slrd),
        .usb_sloe(usb_sloe), .usb_addr(usb_addr), .usb_data_in(usb_data_in),
        .usb_data_out(usb_data_out), .usb_ep2_empty(usb_ep2_empty),
        .usb_ep4_empty(usb_ep4_empty), .usb_ep6_full(usb_ep6_full),
        .ep2_port_data(ep2_port_data), .ep2_port_write(ep2_port_write),
        .ep6_port_addr_ins(port_addr_ins), .ep6_port_addr_outs(port_addr_outs),
        .ep6_port_datas(port_datas), .ep6_port_read(ep6_port_read),
        .cmd_in_id(cmd_in_id), .cmd_in_data(cmd_in_data), .cmd_valid(cmd_valid)
    );

    fx2_checker chk0 (
        .usb_ifclk(usb_ifclk), .reset(reset), .ep2_port_write(ep2_port_write),
        .ep2_port_data(ep2_port_data), .cmd_valid(cmd_valid), .cmd_in_id(cmd_in_id),
        .cmd_in_data(cmd_in_data), .usb_slwr(usb_slwr), .usb_data_in(usb_data_in)
    );

    initial begin
        forever begin
            #5 usb_ifclk = ~usb_ifclk;
        end
    end

    // Run limit grows with the traffic queued so far
    always @(posedge usb_ifclk) begin
        cycles++;
        if (cycles > 20 * total_bytes + 1000) begin
            $display("Timeout after %0d cycles with traffic still pending", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Flags and bus data change on the falling edge
    always @(negedge usb_ifclk) begin
        usb_ep2_empty = (ep2_queue.size() == 0) || (stall_en && ($urandom_range(3) == 0));
        usb_ep4_empty = (ep4_queue.size() == 0) || (stall_en && ($urandom_range(3) == 0));
        usb_ep6_full  = stall_en && ($urandom_range(3) == 0);
        if ((usb_addr == EP2) && (ep2_queue.size() != 0)) begin
            usb_data_out = ep2_queue[0];
        end else if ((usb_addr == EP4) && (ep4_queue.size() != 0)) begin
            usb_data_out = ep4_queue[0];
        end else begin
            usb_data_out = 8'h00;
        end
    end

    // FX2 hands over a byte on each read strobe
    always @(posedge usb_ifclk) begin
        if (!usb_slrd) begin
            if (usb_addr == EP2) begin
                void'(ep2_queue.pop_front());
            end else if (usb_addr == EP4) begin
                void'(ep4_queue.pop_front());
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (ep6_port_read[i]) begin
                out_addr[i] <= out_addr[i] + 1'b1;
            end
        end
    end

    // FIFO model shows the byte at its out-address
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            port_addr_ins[i]  = in_addr[i];
            port_addr_outs[i] = out_addr[i];
            port_datas[i]     = fifo_mem[i][out_addr[i]];
        end
    end

    // Reference frame of start byte FF, id or port, length upper then lower and payload
    function automatic byte_q_t build_frame(input fx2_byte_t id, input byte_q_t data);
        byte_q_t        frame;
        packet_length_t len;
        len   = packet_length_t'(data.size());
        frame = {8'hFF, id, len[15:8], len[7:0]};
        frame = {frame, data};
        return frame;
    endfunction

    function automatic byte_q_t random_bytes(input int n);
        byte_q_t data;
        for (int i = 0; i < n; i++) begin
            data.push_back(fx2_byte_t'($urandom));
        end
        return data;
    endfunction

    // Junk byte goes first and must be dropped while waiting for a start byte
    task automatic send_ep2(input port_index_t port, input int n);
        byte_q_t   data;
        byte_q_t   frame;
        fx2_byte_t hdr;
        data      = random_bytes(n);
        hdr       = fx2_byte_t'($urandom);
        hdr[1:0]  = port;
        frame     = build_frame(hdr, data);
        ep2_queue.push_back(fx2_byte_t'($urandom_range(0, 254)));
        foreach (frame[i]) ep2_queue.push_back(frame[i]);
        foreach (data[i]) chk0.expect_ep2(port, data[i]);
        total_bytes += frame.size() + 1;
    endtask

    task automatic send_cmd(input fx2_byte_t id, input int n);
        byte_q_t data;
        byte_q_t frame;
        data  = random_bytes(n);
        frame = build_frame(id, data);
        foreach (frame[i]) ep4_queue.push_back(frame[i]);
        foreach (data[i]) chk0.expect_cmd(id, data[i]);
        total_bytes += frame.size();
    endtask

    // Loads a whole frame at once and waits for the FIFO to drain
    task automatic send_adc(input port_index_t port, input int n);
        byte_q_t data;
        byte_q_t frame;
        data  = random_bytes(n);
        frame = build_frame(fx2_byte_t'(port), data);
        foreach (data[i]) begin
            fifo_mem[port][in_addr[port]] = data[i];
            in_addr[port] = in_addr[port] + 1'b1;
        end
        foreach (frame[i]) chk0.expect_ep6(frame[i]);
        total_bytes += frame.size();
        while (out_addr[port] != in_addr[port]) @(negedge usb_ifclk);
    endtask

    // Waits for every byte to be delivered and then for a quiet spell with no stray strobes
    task automatic wait_idle();
        while ((ep2_queue.size() != 0) || (ep4_queue.size() != 0) ||
               (chk0.pending() != 0)) begin
            @(negedge usb_ifclk);
        end
        repeat (20) @(negedge usb_ifclk);
    endtask

    initial begin
        void'($urandom(32'h75a3_91e5));
        repeat (4) @(negedge usb_ifclk);
        reset = 1'b0;
        @(negedge usb_ifclk);

        // Idle state right after reset
        chk0.check_value("usb_slwr", 8'h01, 8'(usb_slwr));
        chk0.check_value("usb_slrd", 8'h01, 8'(usb_slrd));
        chk0.check_value("usb_sloe", 8'h00, 8'(usb_sloe));
        chk0.check_value("ep2_port_write", 8'h00, 8'(ep2_port_write));
        chk0.check_value("ep6_port_read", 8'h00, 8'(ep6_port_read));
        chk0.check_value("cmd_valid", 8'h00, 8'(cmd_valid));
        chk0.check_value("cmd_in_id", 8'h38, cmd_in_id);
        chk0.finish_test("reset state");

        for (int p = 0; p < 4; p++) send_ep2(port_index_t'(p), $urandom_range(1, 24));
        wait_idle();
        chk0.finish_test("ep2 ports");

        send_cmd(8'h41, 6);
        send_cmd(8'h52, 0);
        send_cmd(8'h07, 12);
        wait_idle();
        chk0.finish_test("ep4 commands");

        for (int p = 0; p < 4; p++) send_adc(port_index_t'(p), $urandom_range(20, 40));
        wait_idle();
        chk0.finish_test("ep6 frames");

        // All three endpoints busy under random empty and full stalls
        stall_en = 1'b1;
        for (int k = 0; k < 6; k++) begin
            send_ep2(port_index_t'(k % 4), $urandom_range(1, 20));
            send_cmd(fx2_byte_t'($urandom), $urandom_range(0, 10));
        end
        for (int p = 0; p < 4; p++) send_adc(port_index_t'(p), $urandom_range(1, 60));
        wait_idle();
        chk0.finish_test("stalls");

        chk0.report_totals();
        if (chk0.error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
rtl/fx2_bus_pkg.sv
rtl/fifo_port_pkg.sv
rtl/fx2_endpoint_arbiter.sv
rtl/out_packet_reader.sv
rtl/adc_packet_writer.sv
rtl/fx2_interface.sv
bench/fx2_checker.sv
bench/tb_fx2_interface.sv

// File: run.sh
#!/bin/bash
# Build and run the FX2 interface simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_fx2_interface
output=$(./obj_dir/Vtb_fx2_interface)
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi
